// File: common/core_pkg.sv
package core_pkg;

    // general register file
    localparam int gpr_addr_w = 5;

    // csr numbers are 14 bits wide in the instruction encoding
    localparam int csr_num_w = 14;

    localparam logic [csr_num_w-1:0] csr_crmd  = 14'h0000;
    localparam logic [csr_num_w-1:0] csr_prmd  = 14'h0001;
    localparam logic [csr_num_w-1:0] csr_era   = 14'h0006;

    // save0 .. saveN follow each other from here
    localparam logic [csr_num_w-1:0] csr_save0 = 14'h0030;

    // prmd keeps pplv and pie at the crmd field positions
    localparam int crmd_plv_lo = 0;
    localparam int crmd_ie_bit = 2;

    // kernel mode with interrupts off
    localparam logic [31:0] crmd_reset = 32'h0000_0000;

    // hardware limit on save registers
    localparam int max_save_regs = 4;

endpackage

// File: csr/csr_file.sv
`timescale 1ns/100ps

module csr_file #(
    parameter int SAVE_REGS = 4
) (
    input  logic                            clk,
    input  logic                            resetn,

    input  logic [core_pkg::csr_num_w-1:0]  csr_num,
    output logic [31:0]                     csr_rvalue,

    input  logic                            csr_we,
    input  logic [31:0]                     csr_wmask,
    input  logic [31:0]                     csr_wvalue,

    input  logic                            ertn_flush
);

    // never build more save registers than the architecture defines
    localparam int save_n = (SAVE_REGS > core_pkg::max_save_regs) ?
                            core_pkg::max_save_regs : SAVE_REGS;
    localparam int idx_w  = $clog2(core_pkg::max_save_regs);

    logic [1:0]                     crmd_plv;
    logic                           crmd_ie;
    logic [1:0]                     prmd_pplv;
    logic                           prmd_pie;
    logic [31:0]                    era;
    logic [31:0]                    save_q [save_n];

    logic [31:0]                    crmd_value;
    logic [31:0]                    prmd_value;
    logic [31:0]                    crmd_wdata;
    logic [31:0]                    prmd_wdata;

    logic [core_pkg::csr_num_w-1:0] save_off;
    logic                           is_save;
    logic [idx_w-1:0]               save_idx;
    logic [31:0]                    save_rdata;

    // bits under the mask come from the new value
    function automatic logic [31:0] merge(
        input logic [31:0] old_value,
        input logic [31:0] mask,
        input logic [31:0] new_value
    );
        merge = (old_value & ~mask) | (new_value & mask);
    endfunction

    // rebuild full-width images from the stored fields
    always_comb begin
        crmd_value = 32'h0;
        crmd_value[core_pkg::crmd_plv_lo +: 2] = crmd_plv;
        crmd_value[core_pkg::crmd_ie_bit]      = crmd_ie;

        prmd_value = 32'h0;
        prmd_value[core_pkg::crmd_plv_lo +: 2] = prmd_pplv;
        prmd_value[core_pkg::crmd_ie_bit]      = prmd_pie;
    end

    assign crmd_wdata = merge(crmd_value, csr_wmask, csr_wvalue);
    assign prmd_wdata = merge(prmd_value, csr_wmask, csr_wvalue);

    // numbers below save0 wrap around and fall out of range
    assign save_off = csr_num - core_pkg::csr_save0;
    assign is_save  = save_off < save_n;
    assign save_idx = save_off[idx_w-1:0];

    always_comb begin
        save_rdata = 32'h0;
        for (int i = 0; i < save_n; i++) begin
            if (is_save && save_idx == i) begin
                save_rdata = save_q[i];
            end
        end
    end

    always_comb begin
        case (csr_num)
            core_pkg::csr_crmd: csr_rvalue = crmd_value;
            core_pkg::csr_prmd: csr_rvalue = prmd_value;
            core_pkg::csr_era:  csr_rvalue = era;
            // anything unknown reads zero
            default:            csr_rvalue = save_rdata;
        endcase
    end

    // ertn restore of crmd wins over a plain write
    always_ff @(posedge clk) begin
        if (!resetn) begin
            crmd_plv <= core_pkg::crmd_reset[core_pkg::crmd_plv_lo +: 2];
            crmd_ie  <= core_pkg::crmd_reset[core_pkg::crmd_ie_bit];
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (csr_we && csr_num == core_pkg::csr_crmd) begin
            crmd_plv <= crmd_wdata[core_pkg::crmd_plv_lo +: 2];
            crmd_ie  <= crmd_wdata[core_pkg::crmd_ie_bit];
        end
    end

    // prmd
    always_ff @(posedge clk) begin
        if (!resetn) begin
            prmd_pplv <= 2'b00;
            prmd_pie  <= 1'b0;
        end else if (csr_we && csr_num == core_pkg::csr_prmd) begin
            prmd_pplv <= prmd_wdata[core_pkg::crmd_plv_lo +: 2];
            prmd_pie  <= prmd_wdata[core_pkg::crmd_ie_bit];
        end
    end

    // era
    always_ff @(posedge clk) begin
        if (!resetn) begin
            era <= 32'h0;
        end else if (csr_we && csr_num == core_pkg::csr_era) begin
            era <= merge(era, csr_wmask, csr_wvalue);
        end
    end

    // save0..saveN scratch registers
    always_ff @(posedge clk) begin
        for (int i = 0; i < save_n; i++) begin
            if (!resetn) begin
                save_q[i] <= 32'h0;
            end else if (csr_we && is_save && save_idx == i) begin
                save_q[i] <= merge(save_q[i], csr_wmask, csr_wvalue);
            end
        end
    end

endmodule

// File: filelist.f
+incdir+tb
common/core_pkg.sv
verilog/wb_stage.sv
csr/csr_file.sv
verilog/regfile.sv
verilog/wb_subsystem.sv
tb/tb_wb_subsystem.sv

// File: run_sim.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_wb_subsystem -Mdir "$build_dir" -f filelist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/Vtb_wb_subsystem" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "All tests passed" "$log_file"; then
    exit 0
fi
echo "pass message not found in $log_file"
exit 1

// File: tb/tb_wb_tasks.svh
// csr read into a gpr with the result seen on the trace port
task automatic csr_read(
    input string       name,
    input logic [13:0] num,
    input logic [4:0]  dest,
    input logic [31:0] expected
);
    issue(1'b1, dest, random_bits(32), 1'b1, num, 1'b0, 32'h0, 32'h0, 1'b0);
    check_value(name, expected, debug_wb_rf_wdata);
    model_rf[dest] = expected;
endtask

task automatic csr_write(
    input logic [13:0] num,
    input logic [31:0] mask,
    input logic [31:0] value
);
    issue(1'b0, 5'd0, 32'h0, 1'b0, num, 1'b1, mask, value, 1'b0);
endtask

// one idle cycle lets the pending write land
task automatic check_reg(input string name, input logic [4:0] r);
    raddr1 = r;
    bubble();
    check_value(name, model_rf[r], rdata1);
endtask

task automatic test_reset();
    int cycles;
    cycles = 0;
    while (allowin !== 1'b1 && cycles < 10) begin
        @(negedge clk);
        cycles++;
    end
    if (allowin !== 1'b1) begin
        $display("timeout: allowin never went high after reset");
        timed_out = 1'b1;
        test_errors++;
    end
    check_value("reset rf_we", 32'h0, {28'h0, debug_wb_rf_we});
    check_value("reset ertn_flush", 32'h0, {31'h0, ertn_flush});
    model_era = 32'h0;
    for (int i = 0; i < 4; i++) begin
        model_save[i] = 32'h0;
    end
    csr_read("reset crmd", core_pkg::csr_crmd, 5'd1, 32'h0);
    csr_read("reset prmd", core_pkg::csr_prmd, 5'd1, 32'h0);
    csr_read("reset era", core_pkg::csr_era, 5'd1, 32'h0);
    csr_read("reset save0", core_pkg::csr_save0, 5'd1, 32'h0);
    finish_test("reset");
endtask

task automatic test_rf_stream();
    logic [4:0]  waddr;
    logic [4:0]  prev_addr;
    logic [31:0] wdata;
    logic        we;
    prev_addr = 5'd0;
    for (int k = 0; k < 64; k++) begin
        // first pass fills every register
        waddr = (k < 32) ? 5'(k) : 5'(random_bits(5));
        if (k >= 32 && k % 8 == 0) begin
            waddr = 5'd0;
        end
        we     = (k < 32) || (random_bits(2) != 32'h0);
        wdata  = random_bits(32);
        raddr1 = (k < 32) ? 5'd0 : 5'(random_bits(5));
        raddr2 = prev_addr;
        issue(we, waddr, wdata, 1'b0, 14'h0, 1'b0, 32'h0, 32'h0, 1'b0);
        check_value("rf_stream pc", mem_pc, debug_wb_pc);
        check_value("rf_stream we", {28'h0, {4{we}}}, {28'h0, debug_wb_rf_we});
        check_value("rf_stream fwd_we", {31'h0, we}, {31'h0, wb_fwd_we});
        check_value("rf_stream fwd_waddr", {27'h0, waddr}, {27'h0, wb_fwd_waddr});
        check_value("rf_stream fwd_wdata", wdata, wb_fwd_wdata);
        check_value("rf_stream wnum", {27'h0, waddr}, {27'h0, debug_wb_rf_wnum});
        check_value("rf_stream wdata", wdata, debug_wb_rf_wdata);
        check_value("rf_stream rdata1", model_rf[raddr1], rdata1);
        check_value("rf_stream rdata2", model_rf[raddr2], rdata2);
        if (we && waddr != 5'd0) begin
            model_rf[waddr] = wdata;
        end
        prev_addr = waddr;
    end
    finish_test("rf_stream");
endtask

task automatic masked_write(
    input string       name,
    input logic [13:0] num,
    input logic [4:0]  dest,
    input logic [31:0] old_value,
    output logic [31:0] new_value
);
    logic [31:0] mask;
    logic [31:0] value;
    new_value = old_value;
    for (int j = 0; j < 2; j++) begin
        mask      = random_bits(32);
        value     = random_bits(32);
        new_value = (new_value & ~mask) | (value & mask);
        csr_write(num, mask, value);
        csr_read(name, num, dest, new_value);
        check_reg(name, dest);
    end
endtask

task automatic test_csr_masked();
    masked_write("csr_masked save1", core_pkg::csr_save0 + 14'd1, 5'd5,
                 model_save[1], model_save[1]);
    masked_write("csr_masked era", core_pkg::csr_era, 5'd6, model_era, model_era);
    finish_test("csr_masked");
endtask

task automatic test_csr_unimplemented();
    csr_read("csr_unimpl read", 14'h0100, 5'd7, 32'h0);
    // save4 does not exist with four save registers
    csr_write(14'h0034, 32'hffff_ffff, random_bits(32));
    csr_read("csr_unimpl save4", 14'h0034, 5'd7, 32'h0);
    csr_write(core_pkg::csr_crmd, 32'hffff_ffff, 32'hffff_ffff);
    csr_read("csr_unimpl crmd", core_pkg::csr_crmd, 5'd8, 32'h7);
    csr_write(core_pkg::csr_crmd, 32'hffff_ffff, 32'h0);
    finish_test("csr_unimpl");
endtask

task automatic test_ertn();
    model_era = random_bits(32);
    csr_write(core_pkg::csr_prmd, 32'hffff_ffff, 32'h5);
    csr_write(core_pkg::csr_era, 32'hffff_ffff, model_era);
    issue(1'b0, 5'd0, 32'h0, 1'b1, core_pkg::csr_era, 1'b0, 32'h0, 32'h0, 1'b1);
    check_value("ertn flush", 32'h1, {31'h0, ertn_flush});
    check_value("ertn target", model_era, era_target);
    issue(1'b0, 5'd0, 32'h0, 1'b0, 14'h0, 1'b0, 32'h0, 32'h0, 1'b0);
    check_value("ertn pulse", 32'h0, {31'h0, ertn_flush});
    // crmd picks up pplv and pie
    csr_read("ertn crmd", core_pkg::csr_crmd, 5'd9, 32'h5);
    finish_test("ertn");
endtask

task automatic test_bubbles();
    logic [31:0] wdata;
    wdata         = random_bits(32);
    model_save[2] = model_save[2] + 32'h11;
    model_rf[10]  = wdata;
    issue(1'b1, 5'd10, wdata, 1'b0, core_pkg::csr_save0 + 14'd2, 1'b1, 32'hffff_ffff,
          model_save[2], 1'b0);
    check_value("bubble first we", 32'hf, {28'h0, debug_wb_rf_we});
    for (int i = 0; i < 3; i++) begin
        bubble();
        check_value("bubble rf_we", 32'h0, {28'h0, debug_wb_rf_we});
        check_value("bubble fwd_we", 32'h0, {31'h0, wb_fwd_we});
    end
    issue(1'b0, 5'd0, 32'h0, 1'b1, core_pkg::csr_era, 1'b0, 32'h0, 32'h0, 1'b1);
    check_value("bubble first ertn", 32'h1, {31'h0, ertn_flush});
    for (int i = 0; i < 3; i++) begin
        bubble();
        check_value("bubble ertn_flush", 32'h0, {31'h0, ertn_flush});
    end
    csr_read("bubble save2", core_pkg::csr_save0 + 14'd2, 5'd11, model_save[2]);
    check_reg("bubble r10", 5'd10);
    finish_test("bubbles");
endtask

// File: tb/tb_wb_subsystem.sv
`timescale 1ns/100ps

module tb_wb_subsystem;

    logic        clk;
    logic        resetn;

    // memory stage stand-in
    logic        mem_valid;
    logic        mem_rf_we;
    logic [4:0]  mem_rf_waddr;
    logic [31:0] mem_rf_wdata;
    logic [31:0] mem_pc;
    logic        mem_csr_re;
    logic [13:0] mem_csr_num;
    logic        mem_csr_we;
    logic [31:0] mem_csr_wmask;
    logic [31:0] mem_csr_wvalue;
    logic        mem_ertn;
    logic        allowin;

    // decode and fetch side
    logic [4:0]  raddr1;
    logic [31:0] rdata1;
    logic [4:0]  raddr2;
    logic [31:0] rdata2;
    logic        wb_fwd_we;
    logic [4:0]  wb_fwd_waddr;
    logic [31:0] wb_fwd_wdata;
    logic [31:0] era_target;
    logic        ertn_flush;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    // reference state
    logic [31:0] model_rf [32];
    logic [31:0] model_save [4];
    logic [31:0] model_era;
    logic [31:0] lfsr_state;
    logic [31:0] next_pc;
    int          test_errors;
    int          failed_tests;
    int          tests_run;
    bit          timed_out;

    wb_subsystem #(
        .SAVE_REGS (4)
    ) dut0 (.*);

    always #20 clk = ~clk;

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] bits;
        logic        fb;
        bits = 32'h0;
        for (int i = 0; i < count; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    task automatic check_value(
        input string       name,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        assert (actual === expected) else begin
            $display("Mismatch %s expected %08h actual %08h", name, expected, actual);
            test_errors++;
        end
    endtask

    // present one instruction and return at the falling edge where it sits in wb
    task automatic issue(
        input logic        rf_we,
        input logic [4:0]  waddr,
        input logic [31:0] wdata,
        input logic        csr_re,
        input logic [13:0] num,
        input logic        csr_we,
        input logic [31:0] wmask,
        input logic [31:0] wvalue,
        input logic        ertn
    );
        mem_valid      = 1'b1;
        mem_rf_we      = rf_we;
        mem_rf_waddr   = waddr;
        mem_rf_wdata   = wdata;
        mem_csr_re     = csr_re;
        mem_csr_num    = num;
        mem_csr_we     = csr_we;
        mem_csr_wmask  = wmask;
        mem_csr_wvalue = wvalue;
        mem_ertn       = ertn;
        mem_pc         = next_pc;
        next_pc        = next_pc + 32'd4;
        @(negedge clk);
    endtask

    // valid drops while the other fields stay as they were
    task automatic bubble();
        mem_valid = 1'b0;
        @(negedge clk);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

`include "tb_wb_tasks.svh"

    initial begin
        clk            = 1'b0;
        resetn         = 1'b0;
        mem_valid      = 1'b0;
        mem_rf_we      = 1'b0;
        mem_rf_waddr   = 5'd0;
        mem_rf_wdata   = 32'h0;
        mem_pc         = 32'h0;
        mem_csr_re     = 1'b0;
        mem_csr_num    = 14'h0;
        mem_csr_we     = 1'b0;
        mem_csr_wmask  = 32'h0;
        mem_csr_wvalue = 32'h0;
        mem_ertn       = 1'b0;
        raddr1         = 5'd0;
        raddr2         = 5'd0;
        lfsr_state     = 32'h6edc;
        next_pc        = 32'h1c00_0000;
        test_errors    = 0;
        failed_tests   = 0;
        tests_run      = 0;
        timed_out      = 1'b0;
        for (int i = 0; i < 32; i++) begin
            model_rf[i] = 32'h0;
        end
        repeat (3) @(negedge clk);
        resetn = 1'b1;

        test_reset();
        test_rf_stream();
        test_csr_masked();
        test_csr_unimplemented();
        test_ertn();
        test_bubbles();

        $display("tests run %0d, failed %0d", tests_run, failed_tests);
        if (failed_tests == 0 && !timed_out) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: verilog/regfile.sv
`timescale 1ns/100ps

module regfile (
    input  logic                            clk,

    // write port from writeback
    input  logic                            we,
    input  logic [core_pkg::gpr_addr_w-1:0] waddr,
    input  logic [31:0]                     wdata,

    // decode read ports
    input  logic [core_pkg::gpr_addr_w-1:0] raddr1,
    output logic [31:0]                     rdata1,
    input  logic [core_pkg::gpr_addr_w-1:0] raddr2,
    output logic [31:0]                     rdata2
);

    localparam int num_regs = 1 << core_pkg::gpr_addr_w;

    // r0 has no storage
    logic [31:0] regs [num_regs-1:1];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // plain reads so a same-cycle write shows up next cycle
    assign rdata1 = (raddr1 == '0) ? 32'h0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? 32'h0 : regs[raddr2];

endmodule

// File: verilog/wb_stage.sv
`timescale 1ns/100ps

module wb_stage (
    input  logic                             clk,
    input  logic                             resetn,

    // retiring instruction from mem
    input  logic                             mem_valid,
    input  logic                             mem_rf_we,
    input  logic [core_pkg::gpr_addr_w-1:0]  mem_rf_waddr,
    input  logic [31:0]                      mem_rf_wdata,
    input  logic [31:0]                      mem_pc,
    input  logic                             mem_csr_re,
    input  logic [core_pkg::csr_num_w-1:0]   mem_csr_num,
    input  logic                             mem_csr_we,
    input  logic [31:0]                      mem_csr_wmask,
    input  logic [31:0]                      mem_csr_wvalue,
    input  logic                             mem_ertn,
    output logic                             allowin,

    // register file write port
    output logic                             rf_we,
    output logic [core_pkg::gpr_addr_w-1:0]  rf_waddr,
    output logic [31:0]                      rf_wdata,

    // csr file access
    output logic [core_pkg::csr_num_w-1:0]   csr_num,
    input  logic [31:0]                      csr_rvalue,
    output logic                             csr_we,
    output logic [31:0]                      csr_wmask,
    output logic [31:0]                      csr_wvalue,
    output logic                             ertn_flush,

    // trace
    output logic [31:0]                      debug_wb_pc,
    output logic [3:0]                       debug_wb_rf_we,
    output logic [core_pkg::gpr_addr_w-1:0]  debug_wb_rf_wnum,
    output logic [31:0]                      debug_wb_rf_wdata
);

    logic                            wb_valid;

    logic                            wb_rf_we;
    logic                            wb_csr_re;
    logic                            wb_csr_we;
    logic                            wb_ertn;

    logic [core_pkg::gpr_addr_w-1:0] wb_rf_waddr;
    logic [31:0]                     wb_rf_wdata;
    logic [31:0]                     wb_pc;
    logic [core_pkg::csr_num_w-1:0]  wb_csr_num;
    logic [31:0]                     wb_csr_wmask;
    logic [31:0]                     wb_csr_wvalue;

    logic [31:0]                     final_wdata;

    // last stage so nothing can hold it up
    assign allowin = 1'b1;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_valid  <= 1'b0;
            wb_rf_we  <= 1'b0;
            wb_csr_re <= 1'b0;
            wb_csr_we <= 1'b0;
            wb_ertn   <= 1'b0;
        end else begin
            wb_valid <= mem_valid;
            if (mem_valid) begin
                wb_rf_we  <= mem_rf_we;
                wb_csr_re <= mem_csr_re;
                wb_csr_we <= mem_csr_we;
                wb_ertn   <= mem_ertn;
            end
        end
    end

    // instruction payload
    always_ff @(posedge clk) begin
        if (mem_valid) begin
            wb_rf_waddr   <= mem_rf_waddr;
            wb_rf_wdata   <= mem_rf_wdata;
            wb_pc         <= mem_pc;
            wb_csr_num    <= mem_csr_num;
            wb_csr_wmask  <= mem_csr_wmask;
            wb_csr_wvalue <= mem_csr_wvalue;
        end
    end

    // csr reads replace the alu/load result
    assign final_wdata = wb_csr_re ? csr_rvalue : wb_rf_wdata;

    // side effects only while a real instruction sits here
    assign rf_we      = wb_valid & wb_rf_we;
    assign csr_we     = wb_valid & wb_csr_we;
    assign ertn_flush = wb_valid & wb_ertn;

    assign rf_waddr   = wb_rf_waddr;
    assign rf_wdata   = final_wdata;

    assign csr_num    = wb_csr_num;
    assign csr_wmask  = wb_csr_wmask;
    assign csr_wvalue = wb_csr_wvalue;

    assign debug_wb_pc       = wb_pc;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = wb_rf_waddr;
    assign debug_wb_rf_wdata = final_wdata;

endmodule

// File: verilog/wb_subsystem.sv
`timescale 1ns/100ps

module wb_subsystem #(
    parameter int SAVE_REGS = 4
) (
    input  logic                            clk,
    input  logic                            resetn,

    // from the memory stage
    input  logic                            mem_valid,
    input  logic                            mem_rf_we,
    input  logic [core_pkg::gpr_addr_w-1:0] mem_rf_waddr,
    input  logic [31:0]                     mem_rf_wdata,
    input  logic [31:0]                     mem_pc,
    input  logic                            mem_csr_re,
    input  logic [core_pkg::csr_num_w-1:0]  mem_csr_num,
    input  logic                            mem_csr_we,
    input  logic [31:0]                     mem_csr_wmask,
    input  logic [31:0]                     mem_csr_wvalue,
    input  logic                            mem_ertn,
    output logic                            allowin,

    // decode side
    input  logic [core_pkg::gpr_addr_w-1:0] raddr1,
    output logic [31:0]                     rdata1,
    input  logic [core_pkg::gpr_addr_w-1:0] raddr2,
    output logic [31:0]                     rdata2,
    output logic                            wb_fwd_we,
    output logic [core_pkg::gpr_addr_w-1:0] wb_fwd_waddr,
    output logic [31:0]                     wb_fwd_wdata,

    // fetch redirect on ertn
    output logic [31:0]                     era_target,
    output logic                            ertn_flush,

    output logic [31:0]                     debug_wb_pc,
    output logic [3:0]                      debug_wb_rf_we,
    output logic [core_pkg::gpr_addr_w-1:0] debug_wb_rf_wnum,
    output logic [31:0]                     debug_wb_rf_wdata
);

    logic                            rf_we;
    logic [core_pkg::gpr_addr_w-1:0] rf_waddr;
    logic [31:0]                     rf_wdata;

    logic [core_pkg::csr_num_w-1:0]  csr_num;
    logic [31:0]                     csr_rvalue;
    logic                            csr_we;
    logic [31:0]                     csr_wmask;
    logic [31:0]                     csr_wvalue;

    wb_stage u_wb_stage (
        .clk               (clk),
        .resetn            (resetn),
        .mem_valid         (mem_valid),
        .mem_rf_we         (mem_rf_we),
        .mem_rf_waddr      (mem_rf_waddr),
        .mem_rf_wdata      (mem_rf_wdata),
        .mem_pc            (mem_pc),
        .mem_csr_re        (mem_csr_re),
        .mem_csr_num       (mem_csr_num),
        .mem_csr_we        (mem_csr_we),
        .mem_csr_wmask     (mem_csr_wmask),
        .mem_csr_wvalue    (mem_csr_wvalue),
        .mem_ertn          (mem_ertn),
        .allowin           (allowin),
        .rf_we             (rf_we),
        .rf_waddr          (rf_waddr),
        .rf_wdata          (rf_wdata),
        .csr_num           (csr_num),
        .csr_rvalue        (csr_rvalue),
        .csr_we            (csr_we),
        .csr_wmask         (csr_wmask),
        .csr_wvalue        (csr_wvalue),
        .ertn_flush        (ertn_flush),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    csr_file #(
        .SAVE_REGS (SAVE_REGS)
    ) u_csr_file (
        .clk        (clk),
        .resetn     (resetn),
        .csr_num    (csr_num),
        .csr_rvalue (csr_rvalue),
        .csr_we     (csr_we),
        .csr_wmask  (csr_wmask),
        .csr_wvalue (csr_wvalue),
        .ertn_flush (ertn_flush)
    );

    regfile u_regfile (
        .clk    (clk),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata),
        .raddr1 (raddr1),
        .rdata1 (rdata1),
        .raddr2 (raddr2),
        .rdata2 (rdata2)
    );

    // forwarding to decode mirrors the write port
    assign wb_fwd_we    = rf_we;
    assign wb_fwd_waddr = rf_waddr;
    assign wb_fwd_wdata = rf_wdata;

    // an ertn reads era, so the read value is the return address
    assign era_target = csr_rvalue;

endmodule
